// File: tb.f
+incdir+tests
common/lsu_pkg.sv
source/lsu_addr_stage.sv
load_pipe/load_data_align.sv
load_pipe/load_pipe.sv
store_pipe/store_pipe.sv
source/mem_arbiter.sv
source/data_mem.sv
source/exc_tracker.sv
source/lsu_top.sv
tests/lsu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -f tb.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim > sim.log
cat sim.log

# the testbench prints its verdict, the log decides the exit status
grep -q "Verification passed" sim.log

// File: tests/lsu_tb_cases.svh
`ifndef LSU_TB_CASES_SVH
`define LSU_TB_CASES_SVH

// columns: name, load valid rob size uext addr, store valid rob size addr
// then load outcome (0 none, 1 wb, 2 wb misaligned, 3 replay), store outcome
// (0 none, 1 done, 2 misaligned), tracker valid rob code vaddr, clear afterwards
task automatic build_cases();
    add_case("st_word", 1'b0, 6'h00, 2'd0, 1'b0, 10'h000, 1'b1, 6'h01, 2'd2, 10'h040,
             2'd0, 2'd1, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_word", 1'b1, 6'h02, 2'd2, 1'b0, 10'h040, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_byte_s", 1'b1, 6'h03, 2'd0, 1'b0, 10'h041, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_byte_u", 1'b1, 6'h04, 2'd0, 1'b1, 10'h043, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_half_s", 1'b1, 6'h05, 2'd1, 1'b0, 10'h042, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_half_u", 1'b1, 6'h06, 2'd1, 1'b1, 10'h040, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("st_byte", 1'b0, 6'h00, 2'd0, 1'b0, 10'h000, 1'b1, 6'h07, 2'd0, 10'h041,
             2'd0, 2'd1, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("st_half", 1'b0, 6'h00, 2'd0, 1'b0, 10'h000, 1'b1, 6'h08, 2'd1, 10'h042,
             2'd0, 2'd1, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_merged", 1'b1, 6'h09, 2'd2, 1'b0, 10'h040, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_st_same", 1'b1, 6'h0a, 2'd2, 1'b0, 10'h080, 1'b1, 6'h0b, 2'd2, 10'h080,
             2'd3, 2'd1, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_reissue", 1'b1, 6'h0a, 2'd2, 1'b0, 10'h080, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b0, 6'h00, 2'd0, 10'h000, 1'b0);
    add_case("ld_misalign", 1'b1, 6'h0c, 2'd2, 1'b0, 10'h042, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd2, 2'd0, 1'b1, 6'h0c, 2'd1, 10'h042, 1'b1);
    add_case("st_misalign", 1'b0, 6'h00, 2'd0, 1'b0, 10'h000, 1'b1, 6'h0d, 2'd2, 10'h081,
             2'd0, 2'd2, 1'b1, 6'h0d, 2'd2, 10'h081, 1'b0);
    add_case("ld_unchanged", 1'b1, 6'h0e, 2'd2, 1'b0, 10'h080, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd1, 2'd0, 1'b1, 6'h0d, 2'd2, 10'h081, 1'b0);
    add_case("ld_younger", 1'b1, 6'h0f, 2'd1, 1'b0, 10'h083, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd2, 2'd0, 1'b1, 6'h0d, 2'd2, 10'h081, 1'b1);
    add_case("st_wrap_new", 1'b0, 6'h00, 2'd0, 1'b0, 10'h000, 1'b1, 6'h22, 2'd1, 10'h045,
             2'd0, 2'd2, 1'b1, 6'h22, 2'd2, 10'h045, 1'b0);
    add_case("ld_wrap_old", 1'b1, 6'h1e, 2'd2, 1'b0, 10'h046, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd2, 2'd0, 1'b1, 6'h1e, 2'd1, 10'h046, 1'b0);
    add_case("ld_wrap_young", 1'b1, 6'h23, 2'd1, 1'b0, 10'h047, 1'b0, 6'h00, 2'd0, 10'h000,
             2'd2, 2'd0, 1'b1, 6'h1e, 2'd1, 10'h046, 1'b1);
    add_case("pair_fault", 1'b1, 6'h07, 2'd2, 1'b0, 10'h049, 1'b1, 6'h04, 2'd2, 10'h08a,
             2'd2, 2'd2, 1'b1, 6'h04, 2'd2, 10'h08a, 1'b1);
    add_case("ld_bad_st", 1'b1, 6'h11, 2'd2, 1'b0, 10'h040, 1'b1, 6'h12, 2'd1, 10'h043,
             2'd1, 2'd2, 1'b1, 6'h12, 2'd2, 10'h043, 1'b1);
endtask

`endif

// File: tests/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb;

    typedef struct packed {
        lsu_pkg::load_op_t           ld;
        lsu_pkg::store_op_t          st;
        logic [1:0]                  exp_ld;
        logic [1:0]                  exp_st;
        logic                        xv;
        lsu_pkg::rob_idx_t           xrob;
        lsu_pkg::exc_t               xcode;
        logic [lsu_pkg::ADDR_W-1:0]  xaddr;
        logic                        clr;
    } test_t;

    logic                        clk;
    logic                        rst;
    lsu_pkg::load_op_t           load_op;
    lsu_pkg::store_op_t          store_op;
    logic                        exc_clear;
    lsu_pkg::load_wb_t           load_wb;
    lsu_pkg::replay_t            replay;
    lsu_pkg::store_done_t        store_done;
    logic                        exc_valid;
    lsu_pkg::rob_idx_t           exc_rob;
    lsu_pkg::exc_t               exc_code;
    logic [lsu_pkg::ADDR_W-1:0]  exc_vaddr;

    test_t      tests[$];
    string      names[$];
    // byte image of what the memory should hold
    logic [7:0] ref_mem [1024];
    int         errs;
    int         failed_tests;
    bit         built;

    lsu_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .load_op_i     (load_op),
        .store_op_i    (store_op),
        .exc_clear_i   (exc_clear),
        .load_wb_o     (load_wb),
        .load_replay_o (replay),
        .store_done_o  (store_done),
        .exc_valid_o   (exc_valid),
        .exc_rob_o     (exc_rob),
        .exc_code_o    (exc_code),
        .exc_vaddr_o   (exc_vaddr)
    );

    always #4 clk = ~clk;

    task automatic add_case(input string name, input logic lv, input logic [5:0] lrob,
                            input logic [1:0] lsize, input logic luext, input logic [9:0] laddr,
                            input logic sv, input logic [5:0] srob, input logic [1:0] ssize,
                            input logic [9:0] saddr, input logic [1:0] exp_ld,
                            input logic [1:0] exp_st, input logic xv, input logic [5:0] xrob,
                            input logic [1:0] xcode, input logic [9:0] xaddr, input logic clr);
        test_t t;
        t          = '0;
        t.ld.valid = lv;
        t.ld.rob   = lrob;
        t.ld.rd    = 5'(names.size());
        t.ld.size  = lsu_pkg::size_t'(lsize);
        t.ld.uext  = luext;
        // base one word above so the negative immediate brings it back
        t.ld.base  = 32'(laddr) + 32'd4;
        t.ld.imm   = 12'hffc;
        t.st.valid = sv;
        t.st.rob   = srob;
        t.st.size  = lsu_pkg::size_t'(ssize);
        t.st.base  = 32'(saddr) + 32'd4;
        t.st.imm   = 12'hffc;
        t.exp_ld   = exp_ld;
        t.exp_st   = exp_st;
        t.xv       = xv;
        t.xrob     = xrob;
        t.xcode    = lsu_pkg::exc_t'(xcode);
        t.xaddr    = xaddr;
        t.clr      = clr;
        tests.push_back(t);
        names.push_back(name);
    endtask

    `include "lsu_tb_cases.svh"

    function automatic logic misaligned(input lsu_pkg::size_t sz, input logic [9:0] a);
        return (sz == lsu_pkg::SIZE_H && a[0]) || (sz == lsu_pkg::SIZE_W && a[1:0] != 2'b00);
    endfunction

    function automatic logic [31:0] load_value(input logic [9:0] a, input lsu_pkg::size_t sz,
                                               input logic uext);
        logic [31:0] w;
        w = {ref_mem[a + 10'd3], ref_mem[a + 10'd2], ref_mem[a + 10'd1], ref_mem[a]};
        if (sz == lsu_pkg::SIZE_B) begin
            return uext ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
        end else if (sz == lsu_pkg::SIZE_H) begin
            return uext ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
        end
        return w;
    endfunction

    task automatic write_ref(input lsu_pkg::store_op_t op, input logic [9:0] a);
        int n;
        n = (op.size == lsu_pkg::SIZE_B) ? 1 : (op.size == lsu_pkg::SIZE_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a + 10'(i)] = op.data[8*i +: 8];
        end
    endtask

    task automatic compare(input string name, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s %s expected %h actual %h", name, what, exp, act);
            errs++;
        end
    endtask

    task automatic run_test(input int n);
        test_t         t;
        string         name;
        logic [9:0]    la;
        logic [9:0]    sa;
        logic [31:0]   want;
        logic          want_wb;
        lsu_pkg::exc_t want_lexc;
        lsu_pkg::exc_t want_sexc;
        t         = tests[n];
        name      = names[n];
        errs      = 0;
        la        = 10'(t.ld.base - 32'd4);
        sa        = 10'(t.st.base - 32'd4);
        // top bit of each byte set so sign extension shows
        t.st.data = $urandom | 32'h8080_8080;
        want_wb   = t.exp_ld == 2'd1 || t.exp_ld == 2'd2;
        want_lexc = lsu_pkg::EXC_NONE;
        want_sexc = lsu_pkg::EXC_NONE;
        if (t.exp_ld == 2'd2) begin
            want_lexc = lsu_pkg::EXC_LAM;
        end
        if (t.exp_st == 2'd2) begin
            want_sexc = lsu_pkg::EXC_SAM;
        end
        if (t.st.valid && !misaligned(t.st.size, sa)) begin
            write_ref(t.st, sa);
        end
        want = (t.exp_ld == 2'd2) ? 32'h0 : load_value(la, t.ld.size, t.ld.uext);

        @(negedge clk);
        load_op  = t.ld;
        store_op = t.st;
        @(negedge clk);
        load_op  = '0;
        store_op = '0;
        @(negedge clk);

        // results one edge after the address stage
        if (load_wb.valid !== want_wb) begin
            $display("%s: load writeback %s", name, want_wb ? "missing" : "not expected");
            errs++;
        end
        if (replay.valid !== (t.exp_ld == 2'd3)) begin
            $display("%s: load replay %s", name, replay.valid ? "not expected" : "missing");
            errs++;
        end
        if (store_done.valid !== (t.exp_st != 2'd0)) begin
            $display("%s: store done %s", name, store_done.valid ? "not expected" : "missing");
            errs++;
        end
        if (want_wb && load_wb.valid) begin
            compare(name, "wb rob", 32'(t.ld.rob), 32'(load_wb.rob));
            compare(name, "wb rd", 32'(t.ld.rd), 32'(load_wb.rd));
            compare(name, "wb exc", 32'(want_lexc), 32'(load_wb.exc));
            compare(name, "wb data", want, load_wb.data);
        end
        if (t.exp_ld == 2'd3 && replay.valid) begin
            compare(name, "replay rob", 32'(t.ld.rob), 32'(replay.rob));
        end
        if (t.exp_st != 2'd0 && store_done.valid) begin
            compare(name, "done rob", 32'(t.st.rob), 32'(store_done.rob));
            compare(name, "done exc", 32'(want_sexc), 32'(store_done.exc));
        end

        // tracker settles one edge later
        @(negedge clk);
        if (exc_valid !== t.xv) begin
            $display("%s: exception valid is %b, should be %b", name, exc_valid, t.xv);
            errs++;
        end
        if (t.xv && exc_valid) begin
            compare(name, "exc rob", 32'(t.xrob), 32'(exc_rob));
            compare(name, "exc code", 32'(t.xcode), 32'(exc_code));
            compare(name, "exc vaddr", 32'(t.xaddr), 32'(exc_vaddr));
        end
        if (t.clr) begin
            exc_clear = 1'b1;
            @(negedge clk);
            exc_clear = 1'b0;
            if (exc_valid !== 1'b0) begin
                $display("%s: exception still held after clear", name);
                errs++;
            end
        end

        if (errs == 0) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s FAILED with %0d mismatches", name, errs);
            failed_tests++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        load_op      = '0;
        store_op     = '0;
        exc_clear    = 1'b0;
        failed_tests = 0;
        built        = 1'b0;
        void'($urandom(32'hb21));
        build_cases();
        built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d ok, %0d failed", tests.size(), tests.size() - failed_tests,
                 failed_tests);
        if (failed_tests == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // every test fits in 8 cycles of 8 ns
    initial begin
        wait (built);
        #(tests.size() * 8 * 8 + 200);
        $display("timeout: the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: source/lsu_top.sv
`timescale 1ns/10ps

module lsu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  lsu_pkg::load_op_t           load_op_i,
    input  lsu_pkg::store_op_t          store_op_i,
    input  logic                        exc_clear_i,
    output lsu_pkg::load_wb_t           load_wb_o,
    output lsu_pkg::replay_t            load_replay_o,
    output lsu_pkg::store_done_t        store_done_o,
    output logic                        exc_valid_o,
    output lsu_pkg::rob_idx_t           exc_rob_o,
    output lsu_pkg::exc_t               exc_code_o,
    output logic [lsu_pkg::ADDR_W-1:0]  exc_vaddr_o
);

    lsu_pkg::mem_req_t           load_req;
    lsu_pkg::mem_req_t           store_req;
    lsu_pkg::mem_req_t           mem_req;
    logic                        load_grant;
    logic [lsu_pkg::XLEN-1:0]    rdata;
    logic [lsu_pkg::ADDR_W-1:0]  load_vaddr;
    logic [lsu_pkg::ADDR_W-1:0]  store_vaddr;

    load_pipe load_pipe_i (
        .clk       (clk),
        .rst       (rst),
        .load_op_i (load_op_i),
        .req_o     (load_req),
        .grant_i   (load_grant),
        .rdata_i   (rdata),
        .wb_o      (load_wb_o),
        .replay_o  (load_replay_o),
        .vaddr_o   (load_vaddr)
    );

    store_pipe store_pipe_i (
        .clk          (clk),
        .rst          (rst),
        .store_op_i   (store_op_i),
        .req_o        (store_req),
        .store_done_o (store_done_o),
        .vaddr_o      (store_vaddr)
    );

    mem_arbiter arbiter_i (
        .store_req_i  (store_req),
        .load_req_i   (load_req),
        .mem_req_o    (mem_req),
        .load_grant_o (load_grant)
    );

    data_mem mem_i (
        .clk     (clk),
        .req_i   (mem_req),
        .rdata_o (rdata)
    );

    exc_tracker exc_i (
        .clk           (clk),
        .rst           (rst),
        .load_wb_i     (load_wb_o),
        .load_vaddr_i  (load_vaddr),
        .store_done_i  (store_done_o),
        .store_vaddr_i (store_vaddr),
        .exc_clear_i   (exc_clear_i),
        .exc_valid_o   (exc_valid_o),
        .exc_rob_o     (exc_rob_o),
        .exc_code_o    (exc_code_o),
        .exc_vaddr_o   (exc_vaddr_o)
    );

endmodule

// File: source/exc_tracker.sv
`timescale 1ns/10ps

module exc_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  lsu_pkg::load_wb_t           load_wb_i,
    input  logic [lsu_pkg::ADDR_W-1:0]  load_vaddr_i,
    input  lsu_pkg::store_done_t        store_done_i,
    input  logic [lsu_pkg::ADDR_W-1:0]  store_vaddr_i,
    input  logic                        exc_clear_i,
    output logic                        exc_valid_o,
    output lsu_pkg::rob_idx_t           exc_rob_o,
    output lsu_pkg::exc_t               exc_code_o,
    output logic [lsu_pkg::ADDR_W-1:0]  exc_vaddr_o
);

    logic                        l_exc;
    logic                        s_exc;
    logic                        pick_load;
    logic                        take;
    lsu_pkg::rob_idx_t           cand_rob;

    // a older than b, across a wrap when dir differs
    function automatic logic rob_older(lsu_pkg::rob_idx_t a, lsu_pkg::rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    assign l_exc     = load_wb_i.valid & (load_wb_i.exc != lsu_pkg::EXC_NONE);
    assign s_exc     = store_done_i.valid & (store_done_i.exc != lsu_pkg::EXC_NONE);
    assign pick_load = l_exc & (~s_exc | rob_older(load_wb_i.rob, store_done_i.rob));
    assign cand_rob  = pick_load ? load_wb_i.rob : store_done_i.rob;
    assign take      = (l_exc | s_exc) & (~exc_valid_o | rob_older(cand_rob, exc_rob_o));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exc_valid_o <= 1'b0;
        end else if (exc_clear_i) begin
            exc_valid_o <= 1'b0;
        end else if (take) begin
            exc_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            exc_rob_o   <= cand_rob;
            exc_code_o  <= pick_load ? load_wb_i.exc : store_done_i.exc;
            exc_vaddr_o <= pick_load ? load_vaddr_i : store_vaddr_i;
        end
    end

endmodule

// File: source/data_mem.sv
`timescale 1ns/10ps

module data_mem (
    input  logic                     clk,
    input  lsu_pkg::mem_req_t        req_i,
    output logic [lsu_pkg::XLEN-1:0] rdata_o
);

    logic [lsu_pkg::XLEN-1:0] mem [lsu_pkg::MEM_WORDS];

    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            if (req_i.write) begin
                for (int b = 0; b < lsu_pkg::BYTES; b++) begin
                    if (req_i.be[b]) begin
                        mem[req_i.addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[req_i.addr];
            end
        end
    end

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  lsu_pkg::mem_req_t store_req_i,
    input  lsu_pkg::mem_req_t load_req_i,
    output lsu_pkg::mem_req_t mem_req_o,
    output logic              load_grant_o
);

    // store always wins the single port
    always_comb begin
        if (store_req_i.valid) begin
            mem_req_o = store_req_i;
        end else begin
            mem_req_o = load_req_i;
        end
    end

    assign load_grant_o = load_req_i.valid & ~store_req_i.valid;

endmodule

// File: store_pipe/store_pipe.sv
`timescale 1ns/10ps

module store_pipe (
    input  logic                        clk,
    input  logic                        rst,
    input  lsu_pkg::store_op_t          store_op_i,
    output lsu_pkg::mem_req_t           req_o,
    output lsu_pkg::store_done_t        store_done_o,
    output logic [lsu_pkg::ADDR_W-1:0]  vaddr_o
);

    lsu_pkg::store_op_t          s2_op;
    logic [lsu_pkg::ADDR_W-1:0]  s2_addr;
    logic [lsu_pkg::BYTES-1:0]   s2_mask;
    logic                        s2_mis;

    lsu_addr_stage #(.op_t(lsu_pkg::store_op_t)) addr_stage_i (
        .clk        (clk),
        .rst        (rst),
        .op_i       (store_op_i),
        .base_i     (store_op_i.base),
        .imm_i      (store_op_i.imm),
        .size_i     (store_op_i.size),
        .op_o       (s2_op),
        .addr_o     (s2_addr),
        .mask_o     (s2_mask),
        .misalign_o (s2_mis)
    );

    // low bytes of data shifted up to the addressed lane
    assign req_o.valid = s2_op.valid & ~s2_mis;
    assign req_o.write = 1'b1;
    assign req_o.addr  = s2_addr[lsu_pkg::ADDR_W-1:2];
    assign req_o.be    = s2_mask;
    assign req_o.wdata = s2_op.data << {s2_addr[1:0], 3'b000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            store_done_o <= '0;
        end else begin
            store_done_o.valid <= s2_op.valid;
            store_done_o.rob   <= s2_op.rob;
            store_done_o.exc   <= s2_mis ? lsu_pkg::EXC_SAM : lsu_pkg::EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        vaddr_o <= s2_addr;
    end

endmodule

// File: load_pipe/load_pipe.sv
`timescale 1ns/10ps

module load_pipe (
    input  logic                        clk,
    input  logic                        rst,
    input  lsu_pkg::load_op_t           load_op_i,
    output lsu_pkg::mem_req_t           req_o,
    input  logic                        grant_i,
    input  logic [lsu_pkg::XLEN-1:0]    rdata_i,
    output lsu_pkg::load_wb_t           wb_o,
    output lsu_pkg::replay_t            replay_o,
    output logic [lsu_pkg::ADDR_W-1:0]  vaddr_o
);

    lsu_pkg::load_op_t           s2_op;
    logic [lsu_pkg::ADDR_W-1:0]  s2_addr;
    logic [lsu_pkg::BYTES-1:0]   s2_mask;
    logic                        s2_mis;
    lsu_pkg::load_op_t           s3_op;
    logic                        s3_grant;
    logic                        s3_mis;
    logic [lsu_pkg::XLEN-1:0]    s3_data;

    lsu_addr_stage #(.op_t(lsu_pkg::load_op_t)) addr_stage_i (
        .clk        (clk),
        .rst        (rst),
        .op_i       (load_op_i),
        .base_i     (load_op_i.base),
        .imm_i      (load_op_i.imm),
        .size_i     (load_op_i.size),
        .op_o       (s2_op),
        .addr_o     (s2_addr),
        .mask_o     (s2_mask),
        .misalign_o (s2_mis)
    );

    // misaligned loads never reach memory
    assign req_o.valid = s2_op.valid & ~s2_mis;
    assign req_o.write = 1'b0;
    assign req_o.addr  = s2_addr[lsu_pkg::ADDR_W-1:2];
    assign req_o.be    = s2_mask;
    assign req_o.wdata = '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s3_op <= '0;
        end else begin
            s3_op <= s2_op;
        end
    end

    always_ff @(posedge clk) begin
        s3_grant <= grant_i;
        s3_mis   <= s2_mis;
        vaddr_o  <= s2_addr;
    end

    load_data_align align_i (
        .word_i   (rdata_i),
        .offset_i (vaddr_o[1:0]),
        .size_i   (s3_op.size),
        .uext_i   (s3_op.uext),
        .data_o   (s3_data)
    );

    assign wb_o.valid = s3_op.valid & (s3_mis | s3_grant);
    assign wb_o.rob   = s3_op.rob;
    assign wb_o.rd    = s3_op.rd;
    assign wb_o.data  = s3_mis ? '0 : s3_data;
    assign wb_o.exc   = s3_mis ? lsu_pkg::EXC_LAM : lsu_pkg::EXC_NONE;

    // lost the port to a store
    assign replay_o.valid = s3_op.valid & ~s3_mis & ~s3_grant;
    assign replay_o.rob   = s3_op.rob;

endmodule

// File: load_pipe/load_data_align.sv
`timescale 1ns/10ps

module load_data_align (
    input  logic [lsu_pkg::XLEN-1:0] word_i,
    input  logic [1:0]               offset_i,
    input  lsu_pkg::size_t           size_i,
    input  logic                     uext_i,
    output logic [lsu_pkg::XLEN-1:0] data_o
);

    logic [2*lsu_pkg::XLEN-1:0] doubled;
    logic [lsu_pkg::XLEN-1:0]   rot;

    // addressed byte moves to lane 0
    assign doubled = {word_i, word_i} >> {offset_i, 3'b000};
    assign rot     = doubled[lsu_pkg::XLEN-1:0];

    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_B: data_o = {{(lsu_pkg::XLEN-8){~uext_i & rot[7]}}, rot[7:0]};
            lsu_pkg::SIZE_H: data_o = {{(lsu_pkg::XLEN-16){~uext_i & rot[15]}}, rot[15:0]};
            default:         data_o = rot;
        endcase
    end

endmodule

// File: source/lsu_addr_stage.sv
`timescale 1ns/10ps

module lsu_addr_stage #(
    parameter type op_t = lsu_pkg::load_op_t
) (
    input  logic                             clk,
    input  logic                             rst,
    input  op_t                              op_i,
    input  logic [lsu_pkg::XLEN-1:0]         base_i,
    input  logic [lsu_pkg::IMM_W-1:0]        imm_i,
    input  lsu_pkg::size_t                   size_i,
    output op_t                              op_o,
    output logic [lsu_pkg::ADDR_W-1:0]       addr_o,
    output logic [lsu_pkg::BYTES-1:0]        mask_o,
    output logic                             misalign_o
);

    logic [lsu_pkg::XLEN-1:0]  sum;
    logic [lsu_pkg::BYTES-1:0] mask;
    logic                      misalign;

    assign sum = base_i + {{(lsu_pkg::XLEN-lsu_pkg::IMM_W){imm_i[lsu_pkg::IMM_W-1]}}, imm_i};

    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_B: begin
                mask     = 4'b0001 << sum[1:0];
                misalign = 1'b0;
            end
            lsu_pkg::SIZE_H: begin
                mask     = 4'b0011 << sum[1:0];
                misalign = sum[0];
            end
            default: begin
                mask     = 4'b1111;
                misalign = |sum[1:0];
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_o <= '0;
        end else begin
            op_o <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_o     <= sum[lsu_pkg::ADDR_W-1:0];
        mask_o     <= mask;
        misalign_o <= misalign;
    end

endmodule

// File: common/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN      = 32;
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);
    localparam int ADDR_W    = 10;
    localparam int BYTES     = 4;
    localparam int ROB_W     = 5;
    localparam int IMM_W     = 12;
    localparam int REG_W     = 5;

    // dir flips each time the ROB index wraps
    typedef struct packed {
        logic             dir;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } size_t;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_LAM  = 2'd1,
        EXC_SAM  = 2'd2
    } exc_t;

    typedef struct packed {
        logic             valid;
        rob_idx_t         rob;
        logic [REG_W-1:0] rd;
        size_t            size;
        logic             uext;
        logic [XLEN-1:0]  base;
        logic [IMM_W-1:0] imm;
    } load_op_t;

    typedef struct packed {
        logic             valid;
        rob_idx_t         rob;
        size_t            size;
        logic [XLEN-1:0]  base;
        logic [IMM_W-1:0] imm;
        logic [XLEN-1:0]  data;
    } store_op_t;

    // word addressed, be selects byte lanes on a write
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [MEM_AW-1:0] addr;
        logic [BYTES-1:0]  be;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic             valid;
        rob_idx_t         rob;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
        exc_t             exc;
    } load_wb_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob;
    } replay_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob;
        exc_t     exc;
    } store_done_t;

endpackage
